// File: rtl/decodeFrontEnd.sv
// Instruction decode front end
// Fetch sequencer, credit-controlled queue and decode stage behind plain ports
`timescale 1ns/1ps

module decodeFrontEnd
(
	input logic clk,
	input logic rst,
	// Instruction source side
	input logic inValid,
	input decodePkg::instrWord_t inInstr,
	output logic inReady,
	// Decoded record sink side
	output logic outValid,
	input logic outReady,
	output decodePkg::pc_t outPc,
	output decodePkg::opcode_t outOpcode,
	output logic isLoad,
	output logic isCLoad,
	output logic isCLoadTags,
	output logic isStore,
	output decodePkg::accessSize_t accessSize
);
	import decodePkg::*;

	// Queue head towards the decode stage
	logic qValid;
	logic qPop;
	instrWord_t qWord;
	pc_t qPc;

	// Fetch to queue channel
	instrChannelIf chan();

	fetchSequencer u_fetchSequencer
	(
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.inInstr(inInstr),
		.inReady(inReady),
		.chan(chan.sender)
	);

	instrQueue u_instrQueue
	(
		.clk(clk),
		.rst(rst),
		.qPop(qPop),
		.qValid(qValid),
		.qWord(qWord),
		.qPc(qPc),
		.chan(chan.receiver)
	);

	decodeStage u_decodeStage
	(
		.clk(clk),
		.rst(rst),
		.qValid(qValid),
		.qWord(qWord),
		.qPc(qPc),
		.outReady(outReady),
		.qPop(qPop),
		.outValid(outValid),
		.outPc(outPc),
		.outOpcode(outOpcode),
		.isLoad(isLoad),
		.isCLoad(isCLoad),
		.isCLoadTags(isCLoadTags),
		.isStore(isStore),
		.accessSize(accessSize)
	);

endmodule

// File: rtl/decodePkg.sv
// Shared types and constants for the instruction decode front end
// Opcode map, access size codes and queue sizing live here
package decodePkg;

	// ============================================================
	// Field and word types
	// ============================================================

	// Raw 32-bit instruction word as fetched
	typedef logic [31:0] instrWord_t;
	// Major opcode, bits 6 to 0 of the word
	typedef logic [6:0] opcode_t;
	// Capability function field, bits 31 to 25 under OP_CAP
	typedef logic [6:0] capFunc_t;
	// Byte address of an instruction
	typedef logic [31:0] pc_t;
	// Memory access size code
	typedef logic [2:0] accessSize_t;

	// Credit counter holds 0 to QUEUE_DEPTH inclusive
	typedef logic [2:0] creditCount_t;
	// Index into the instruction queue slots
	typedef logic [1:0] queuePtr_t;

	// ============================================================
	// Access size codes
	// ============================================================

	localparam accessSize_t SZ_NONE  = 3'd0;
	localparam accessSize_t SZ_BYTE  = 3'd1;
	localparam accessSize_t SZ_WYDE  = 3'd2;
	localparam accessSize_t SZ_TETRA = 3'd3;
	localparam accessSize_t SZ_OCTA  = 3'd4;
	localparam accessSize_t SZ_HEXI  = 3'd5;

	// ============================================================
	// Major opcodes
	// ============================================================

	// Loads, signed and unsigned forms for each width up to octa
	localparam opcode_t OP_LDB  = 7'h40;
	localparam opcode_t OP_LDBU = 7'h41;
	localparam opcode_t OP_LDW  = 7'h42;
	localparam opcode_t OP_LDWU = 7'h43;
	localparam opcode_t OP_LDT  = 7'h44;
	localparam opcode_t OP_LDTU = 7'h45;
	localparam opcode_t OP_LDO  = 7'h46;
	localparam opcode_t OP_LDOU = 7'h47;
	localparam opcode_t OP_LDH  = 7'h48;
	// Indirect jump fetches its target from memory, so it counts as a load
	localparam opcode_t OP_JSRI = 7'h4A;

	// Stores
	localparam opcode_t OP_STB = 7'h50;
	localparam opcode_t OP_STW = 7'h51;
	localparam opcode_t OP_STT = 7'h52;
	localparam opcode_t OP_STO = 7'h53;
	localparam opcode_t OP_STH = 7'h54;

	// Capability memory operations and the capability group opcode
	localparam opcode_t OP_CLOAD  = 7'h4C;
	localparam opcode_t OP_CSTORE = 7'h5C;
	localparam opcode_t OP_CAP    = 7'h3C;

	// Function code under OP_CAP that reads the tag bits of a line
	localparam capFunc_t FN_CLOADTAGS = 7'h12;

	// ============================================================
	// Sizing
	// ============================================================

	// Instructions are fixed width, four bytes each
	localparam int INSTR_BYTES = 4;
	// Queue slots, also the number of credits the fetch side starts with
	localparam int QUEUE_DEPTH = 4;

endpackage

// File: rtl/decodeStage.sv
// Decode stage
// Pops queued words, classifies loads and stores, and holds the record under back-pressure
`timescale 1ns/1ps

module decodeStage
(
	input logic clk,
	input logic rst,
	input logic qValid,
	input decodePkg::instrWord_t qWord,
	input decodePkg::pc_t qPc,
	input logic outReady,
	output logic qPop,
	output logic outValid,
	output decodePkg::pc_t outPc,
	output decodePkg::opcode_t outOpcode,
	output logic isLoad,
	output logic isCLoad,
	output logic isCLoadTags,
	output logic isStore,
	output decodePkg::accessSize_t accessSize
);
	import decodePkg::*;

	// ============================================================
	// Combinational decode of the queue head
	// ============================================================

	logic ldHit;
	logic cldHit;
	logic tagHit;
	accessSize_t ldSize;
	logic stHit;
	accessSize_t stSize;
	opcode_t opcode;

	assign opcode = qWord[6:0];

	loadDecoder u_loadDecoder
	(
		.word(qWord),
		.isLoad(ldHit),
		.isCLoad(cldHit),
		.isCLoadTags(tagHit),
		.loadSize(ldSize)
	);

	// Store classification, capability store moves a full hexi
	always_comb
	begin
		stHit = 1'b1;
		stSize = SZ_NONE;
		case (opcode)
			OP_STB:
				stSize = SZ_BYTE;
			OP_STW:
				stSize = SZ_WYDE;
			OP_STT:
				stSize = SZ_TETRA;
			OP_STO:
				stSize = SZ_OCTA;
			OP_STH, OP_CSTORE:
				stSize = SZ_HEXI;
			default:
				stHit = 1'b0;
		endcase
	end

	// ============================================================
	// Output register
	// ============================================================

	// Take a new word when the register is empty or emptying this cycle
	assign qPop = qValid && (!outValid || outReady);

	always_ff @(posedge clk)
	begin
		if (rst)
			outValid <= 1'b0;
		else if (qPop)
			outValid <= 1'b1;
		else if (outReady)
			outValid <= 1'b0;
	end

	// Record only changes on a pop, so a stalled record holds
	always_ff @(posedge clk)
	begin
		if (qPop)
		begin
			outPc <= qPc;
			outOpcode <= opcode;
			isLoad <= ldHit;
			isCLoad <= cldHit;
			isCLoadTags <= tagHit;
			isStore <= stHit;
			// Loads and stores never overlap so one size is always SZ_NONE
			accessSize <= stHit ? stSize : ldSize;
		end
	end

endmodule

// File: rtl/fetchSequencer.sv
// Fetch sequencer
// Accepts instruction words, tags them with a PC and pushes them under credit control
`timescale 1ns/1ps

module fetchSequencer
(
	input logic clk,
	input logic rst,
	input logic inValid,
	input decodePkg::instrWord_t inInstr,
	output logic inReady,
	instrChannelIf.sender chan
);
	import decodePkg::*;

	// ============================================================
	// Credit tracking
	// ============================================================

	// Credits left, one per free queue slot not yet claimed
	creditCount_t credits;
	// Word accepted from the source this cycle
	logic take;

	// Ready only while at least one credit remains
	assign inReady = (credits != '0);
	assign take = inValid && inReady;

	// A take and a return in the same cycle cancel out
	always_ff @(posedge clk)
	begin
		if (rst)
			credits <= creditCount_t'(QUEUE_DEPTH);
		else if (take && !chan.creditReturn)
			credits <= credits - 3'd1;
		else if (!take && chan.creditReturn)
			credits <= credits + 3'd1;
	end

	// ============================================================
	// Program counter and push stage
	// ============================================================

	// Address of the next word to be accepted
	pc_t pcNext;
	// Registered push stage
	logic pushReg;
	instrWord_t wordReg;
	pc_t pcReg;

	// PC steps by one instruction per accepted word
	always_ff @(posedge clk)
	begin
		if (rst)
			pcNext <= '0;
		else if (take)
			pcNext <= pcNext + pc_t'(INSTR_BYTES);
	end

	// Push strobe goes out the cycle after acceptance
	always_ff @(posedge clk)
	begin
		if (rst)
			pushReg <= 1'b0;
		else
			pushReg <= take;
	end

	// Payload only matters while pushReg is set
	always_ff @(posedge clk)
	begin
		if (take)
		begin
			wordReg <= inInstr;
			pcReg <= pcNext;
		end
	end

	assign chan.push = pushReg;
	assign chan.word = wordReg;
	assign chan.pc = pcReg;

endmodule

// File: rtl/instrChannelIf.sv
// Credit-controlled channel from the fetch sequencer to the instruction queue
// Carries pushed words with their PCs forward and credit pulses back
`timescale 1ns/1ps

interface instrChannelIf;
	import decodePkg::*;

	// One-cycle strobe, word and pc are valid with it
	logic push;
	instrWord_t word;
	pc_t pc;
	// One-cycle pulse per slot freed in the queue
	logic creditReturn;

	// Fetch side drives the forward signals
	modport sender
	(
		output push,
		output word,
		output pc,
		input creditReturn
	);

	// Queue side drives the credit return
	modport receiver
	(
		input push,
		input word,
		input pc,
		output creditReturn
	);

endinterface

// File: rtl/instrQueue.sv
// Instruction queue
// Circular buffer of tagged words that hands a credit back for every pop
`timescale 1ns/1ps

module instrQueue
(
	input logic clk,
	input logic rst,
	input logic qPop,
	output logic qValid,
	output decodePkg::instrWord_t qWord,
	output decodePkg::pc_t qPc,
	instrChannelIf.receiver chan
);
	import decodePkg::*;

	// ============================================================
	// Storage
	// ============================================================

	// Slot contents, written on push and read at the head
	instrWord_t wordMem [QUEUE_DEPTH];
	pc_t pcMem [QUEUE_DEPTH];

	// Head and tail positions, both wrap naturally at the slot count
	queuePtr_t rdPtr;
	queuePtr_t wrPtr;
	// Occupancy, 0 to QUEUE_DEPTH, shares the credit width
	creditCount_t count;
	// Registered credit pulse
	logic creditReg;

	// Write the tail slot on each push
	// The sender cannot push without a credit so the slot is always free
	always_ff @(posedge clk)
	begin
		if (chan.push)
		begin
			wordMem[wrPtr] <= chan.word;
			pcMem[wrPtr] <= chan.pc;
		end
	end

	// ============================================================
	// Pointers and occupancy
	// ============================================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
		end
		else
		begin
			if (chan.push)
				wrPtr <= wrPtr + 2'd1;
			if (qPop)
				rdPtr <= rdPtr + 2'd1;
		end
	end

	// Push and pop together leave the count unchanged
	always_ff @(posedge clk)
	begin
		if (rst)
			count <= '0;
		else if (chan.push && !qPop)
			count <= count + 3'd1;
		else if (!chan.push && qPop)
			count <= count - 3'd1;
	end

	// Each pop frees one slot, so one credit goes back on the next cycle
	always_ff @(posedge clk)
	begin
		if (rst)
			creditReg <= 1'b0;
		else
			creditReg <= qPop;
	end

	assign chan.creditReturn = creditReg;

	// ============================================================
	// Head presentation
	// ============================================================

	// A word pushed in one cycle shows up here on the next
	assign qValid = (count != '0);
	assign qWord = wordMem[rdPtr];
	assign qPc = pcMem[rdPtr];

endmodule

// File: rtl/loadDecoder.sv
// Load decoder
// Classifies load-type opcodes and gives the access size of each load
`timescale 1ns/1ps

module loadDecoder
(
	input decodePkg::instrWord_t word,
	output logic isLoad,
	output logic isCLoad,
	output logic isCLoadTags,
	output decodePkg::accessSize_t loadSize
);
	import decodePkg::*;

	opcode_t opcode;
	capFunc_t capFunc;

	assign opcode = word[6:0];
	// Only meaningful when the opcode is OP_CAP
	assign capFunc = word[31:25];

	// Plain loads and their widths
	// Signed and unsigned forms share a size
	always_comb
	begin
		isLoad = 1'b1;
		loadSize = SZ_NONE;
		case (opcode)
			OP_LDB, OP_LDBU:
				loadSize = SZ_BYTE;
			OP_LDW, OP_LDWU:
				loadSize = SZ_WYDE;
			OP_LDT, OP_LDTU:
				loadSize = SZ_TETRA;
			OP_LDO, OP_LDOU:
				loadSize = SZ_OCTA;
			OP_LDH:
				loadSize = SZ_HEXI;
			// The jump target is a full octa pointer
			OP_JSRI:
				loadSize = SZ_OCTA;
			// Capability load reads a whole capability, not flagged as plain load
			OP_CLOAD:
			begin
				isLoad = 1'b0;
				loadSize = SZ_HEXI;
			end
			default:
				isLoad = 1'b0;
		endcase
	end

	assign isCLoad = (opcode == OP_CLOAD);

	// Tag load comes from the function field under the capability group
	assign isCLoadTags = (opcode == OP_CAP) && (capFunc == FN_CLOADTAGS);

endmodule

// File: testbench/decodePatterns.txt
// Columns: instruction word, isLoad, isCLoad, isCLoadTags, isStore, accessSize
// Size codes: 0 none, 1 byte, 2 wyde, 3 tetra, 4 octa, 5 hexi
00a10040 1 0 0 0 1 // LDB
12345041 1 0 0 0 1 // LDBU
00b200c2 1 0 0 0 2 // LDW, bit 7 set above the opcode
7f000043 1 0 0 0 2 // LDWU
0000a044 1 0 0 0 3 // LDT
24000045 1 0 0 0 3 // LDTU with tag-load function bits
fedc3046 1 0 0 0 4 // LDO
00000047 1 0 0 0 4 // LDOU
01020348 1 0 0 0 5 // LDH
0040004a 1 0 0 0 4 // JSRI
2400003c 0 0 1 0 0 // CAP with CLOADTAGS function
0030004c 0 1 0 0 5 // CLOAD
2600003c 0 0 0 0 0 // CAP with another function
00000050 0 0 0 1 1 // STB
0abc0051 0 0 0 1 2 // STW
000000d2 0 0 0 1 3 // STT, bit 7 set above the opcode
11110053 0 0 0 1 4 // STO
00000054 0 0 0 1 5 // STH
0000005c 0 0 0 1 5 // CSTORE
00000013 0 0 0 0 0 // non-memory
00c50033 0 0 0 0 0 // non-memory
0000006f 0 0 0 0 0 // non-memory
2400004c 0 1 0 0 5 // CLOAD with tag-load function bits
fe00003c 0 0 0 0 0 // CAP with function 7f

// File: testbench/tbDecodeFrontEnd.sv
// Testbench for the instruction decode front end
// Replays the pattern file through the DUT with random input gaps and output stalls
`timescale 1ns/1ps

module tbDecodeFrontEnd;
	import decodePkg::*;

	// Room for up to 64 pattern lines of six columns each
	localparam int MAX_PATTERNS = 64;
	localparam int COLS = 6;

	logic clk;
	logic rst;
	logic inValid;
	instrWord_t inInstr;
	logic inReady;
	logic outValid;
	logic outReady;
	pc_t outPc;
	opcode_t outOpcode;
	logic isLoad;
	logic isCLoad;
	logic isCLoadTags;
	logic isStore;
	accessSize_t accessSize;

	// Flat pattern memory with word, isLoad, isCLoad, isCLoadTags, isStore and accessSize
	logic [31:0] patMem [0:COLS*MAX_PATTERNS-1];
	int numPatterns = 0;
	// Words accepted by the DUT and records seen at the output
	int sendIdx = 0;
	int outIdx = 0;
	integer seed;

	decodeFrontEnd u_decodeFrontEnd
	(
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.inInstr(inInstr),
		.inReady(inReady),
		.outValid(outValid),
		.outReady(outReady),
		.outPc(outPc),
		.outOpcode(outOpcode),
		.isLoad(isLoad),
		.isCLoad(isCLoad),
		.isCLoadTags(isCLoadTags),
		.isStore(isStore),
		.accessSize(accessSize)
	);

	// 40 ns clock period
	initial
	begin
		clk = 1'b0;
		forever
		begin
			#20 clk = ~clk;
		end
	end

	// ============================================================
	// Check helpers
	// ============================================================

	task automatic checkValue(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("MISMATCH %s expected 0x%0h actual 0x%0h", testName, expected, actual);
			$display("Test failed");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	task automatic abortRun(input string why);
		$display("ERROR: %s", why);
		$display("Test failed");
		$fatal(1, "Run aborted");
	endtask

	// ============================================================
	// Stimulus
	// ============================================================

	initial
	begin
		int cyc;
		seed = 32'hd4ba;
		rst = 1'b1;
		inValid = 1'b0;
		inInstr = '0;
		outReady = 1'b0;
		$readmemh("testbench/decodePatterns.txt", patMem);
		// Unloaded entries stay X so the first X word ends the list
		while (numPatterns < MAX_PATTERNS && patMem[COLS*numPatterns] !== 'x)
			numPatterns++;
		if (numPatterns < QUEUE_DEPTH + 2)
			abortRun("pattern file is missing or holds too few patterns");

		// Eight clock edges with reset high and the output quiet throughout
		repeat (8)
		begin
			@(posedge clk);
			#2;
			checkValue("reset outValid", 1'b0, outValid);
		end
		rst = 1'b0;
		// First cycle out of reset
		@(posedge clk);
		#2;
		checkValue("after reset outValid", 1'b0, outValid);
		checkValue("after reset inReady", 1'b1, inReady);

		// With the sink stalled only the queue slots and the output register can fill
		for (cyc = 0; cyc < 20; cyc++)
		begin
			inValid = 1'b1;
			inInstr = patMem[COLS*sendIdx];
			@(negedge clk);
			if (inReady)
				sendIdx++;
			@(posedge clk);
			#2;
		end
		inValid = 1'b0;
		checkValue("credit limit accepted words", QUEUE_DEPTH + 1, sendIdx);
		checkValue("credit limit inReady", 1'b0, inReady);

		// Remaining patterns with random source gaps and sink stalls
		while (sendIdx < numPatterns)
		begin
			inValid = (($random(seed) & 3) != 0);
			inInstr = patMem[COLS*sendIdx];
			outReady = (($random(seed) & 3) != 0);
			@(negedge clk);
			if (inValid && inReady)
				sendIdx++;
			@(posedge clk);
			#2;
		end
		inValid = 1'b0;

		// Drain what is still in flight while stalls continue
		while (outIdx < numPatterns)
		begin
			outReady = (($random(seed) & 3) != 0);
			@(posedge clk);
			#2;
		end

		// A few idle cycles with the sink open to catch duplicated records
		outReady = 1'b1;
		repeat (10)
		begin
			@(posedge clk);
			#2;
		end

		$display("Test completed successfully");
		$finish;
	end

	// ============================================================
	// Output monitor
	// ============================================================

	// Sampling at the falling edge sees inputs and outputs both settled
	initial
	begin
		logic holdPending;
		pc_t holdPc;
		opcode_t holdOpcode;
		logic [3:0] holdFlags;
		accessSize_t holdSize;
		instrWord_t expWord;
		int base;
		holdPending = 1'b0;
		forever
		begin
			@(negedge clk);
			if (!rst)
			begin
				// A stalled record must not move until it is taken
				if (holdPending)
				begin
					checkValue("stall outValid", 1'b1, outValid);
					checkValue("stall outPc", holdPc, outPc);
					checkValue("stall outOpcode", holdOpcode, outOpcode);
					checkValue("stall flags", holdFlags, {isLoad, isCLoad, isCLoadTags, isStore});
					checkValue("stall accessSize", holdSize, accessSize);
				end
				if (outValid && outReady)
				begin
					if (outIdx >= numPatterns)
						abortRun("an output record came out with no pattern left to match");
					else
					begin
						base = COLS * outIdx;
						expWord = patMem[base];
						// PC counts four bytes per word in input order
						checkValue($sformatf("pattern %0d outPc", outIdx), outIdx * 4, outPc);
						checkValue($sformatf("pattern %0d outOpcode", outIdx), expWord[6:0],
							outOpcode);
						checkValue($sformatf("pattern %0d isLoad", outIdx), patMem[base+1], isLoad);
						checkValue($sformatf("pattern %0d isCLoad", outIdx), patMem[base+2],
							isCLoad);
						checkValue($sformatf("pattern %0d isCLoadTags", outIdx), patMem[base+3],
							isCLoadTags);
						checkValue($sformatf("pattern %0d isStore", outIdx), patMem[base+4],
							isStore);
						checkValue($sformatf("pattern %0d accessSize", outIdx), patMem[base+5],
							accessSize);
						outIdx++;
					end
				end
				holdPending = outValid && !outReady;
				holdPc = outPc;
				holdOpcode = outOpcode;
				holdFlags = {isLoad, isCLoad, isCLoadTags, isStore};
				holdSize = accessSize;
			end
		end
	end

	// ============================================================
	// Watchdog
	// ============================================================

	// The pattern count is settled by the first clock edge
	initial
	begin
		@(posedge clk);
		repeat (numPatterns * 20 + 200) @(posedge clk);
		abortRun("watchdog expired before all records came out");
	end

endmodule

// File: vlog.f
rtl/decodePkg.sv
rtl/instrChannelIf.sv
rtl/fetchSequencer.sv
rtl/instrQueue.sv
rtl/loadDecoder.sv
rtl/decodeStage.sv
rtl/decodeFrontEnd.sv
testbench/tbDecodeFrontEnd.sv
